//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
TOP       := tb_fp_shuffle_unit
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
src/simd_pkg.sv
src/operand_mux.sv
src/lane_shuffle.sv
src/shuffle_ctrl.sv
src/fp_shuffle_unit.sv
tb/tb_fp_shuffle_unit.sv

//--- src/fp_shuffle_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fp_shuffle_unit #(
  parameter int lane_w = simd_pkg::half_w,
  parameter int tag_bits = simd_pkg::tag_w
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,
  input  simd_pkg::issue_t     iss,
  input  simd_pkg::opsel_t     sel,
  input  simd_pkg::simd_word_t reg_a,
  input  simd_pkg::simd_word_t reg_b,
  input  simd_pkg::simd_word_t fwd0,
  input  simd_pkg::simd_word_t fwd1,
  input  simd_pkg::simd_word_t fwd2,
  input  simd_pkg::simd_word_t alt0,
  input  simd_pkg::simd_word_t alt1,
  output simd_pkg::ret_t       ret
);
  import simd_pkg::*;

  logic [lane_w-1:0]   hi_a;
  logic [lane_w-1:0]   hi_b;
  logic [lane_w-1:0]   lo_a;
  logic [lane_w-1:0]   lo_b;
  logic [lane_w-1:0]   hi_xa;
  logic [lane_w-1:0]   hi_xb;
  logic [lane_w-1:0]   lo_xa;
  logic [lane_w-1:0]   lo_xb;
  src_t                src_hi;
  src_t                src_lo;
  logic                v_hi;
  logic                v_lo;
  logic [tag_bits-1:0] tag;
  logic                hi_valid;
  logic                lo_valid;
  logic [tag_bits-1:0] hi_tag;
  logic [tag_bits-1:0] lo_tag;
  logic [lane_w-1:0]   hi_data;
  logic [lane_w-1:0]   lo_data;
  ret_t                ret_hi;
  ret_t                ret_lo;

  shuffle_ctrl #(.tag_bits(tag_bits)) u_ctrl (
    .clk(clk), .rst(rst), .en(en), .iss(iss),
    .src_hi(src_hi), .src_lo(src_lo),
    .v_hi(v_hi), .v_lo(v_lo), .tag(tag)
  );

  operand_mux #(.lane_w(lane_w)) u_mux_hi_a (
    .reg_val(reg_a.hi), .fwd0(fwd0.hi), .fwd1(fwd1.hi), .fwd2(fwd2.hi),
    .alt_val(alt0.hi), .fwd_sel(sel.fwd_a), .use_alt(sel.alt[0]), .opnd(hi_a)
  );

  operand_mux #(.lane_w(lane_w)) u_mux_hi_b (
    .reg_val(reg_b.hi), .fwd0(fwd0.hi), .fwd1(fwd1.hi), .fwd2(fwd2.hi),
    .alt_val(alt1.hi), .fwd_sel(sel.fwd_b), .use_alt(sel.alt[1]), .opnd(hi_b)
  );

  operand_mux #(.lane_w(lane_w)) u_mux_lo_a (
    .reg_val(reg_a.lo), .fwd0(fwd0.lo), .fwd1(fwd1.lo), .fwd2(fwd2.lo),
    .alt_val(alt0.lo), .fwd_sel(sel.fwd_a), .use_alt(sel.alt[0]), .opnd(lo_a)
  );

  operand_mux #(.lane_w(lane_w)) u_mux_lo_b (
    .reg_val(reg_b.lo), .fwd0(fwd0.lo), .fwd1(fwd1.lo), .fwd2(fwd2.lo),
    .alt_val(alt1.lo), .fwd_sel(sel.fwd_b), .use_alt(sel.alt[1]), .opnd(lo_b)
  );

  // the two halves see each other's stage 1 operands.
  lane_shuffle #(.lane_w(lane_w), .tag_bits(tag_bits)) u_hi (
    .clk(clk), .rst(rst), .opnd_a(hi_a), .opnd_b(hi_b),
    .other_a(lo_xa), .other_b(lo_xb), .src(src_hi), .v(v_hi), .tag(tag),
    .x_a(hi_xa), .x_b(hi_xb),
    .r_valid(hi_valid), .r_tag(hi_tag), .r_data(hi_data)
  );

  lane_shuffle #(.lane_w(lane_w), .tag_bits(tag_bits)) u_lo (
    .clk(clk), .rst(rst), .opnd_a(lo_a), .opnd_b(lo_b),
    .other_a(hi_xa), .other_b(hi_xb), .src(src_lo), .v(v_lo), .tag(tag),
    .x_a(lo_xa), .x_b(lo_xb),
    .r_valid(lo_valid), .r_tag(lo_tag), .r_data(lo_data)
  );

  assign ret_hi = '{valid: hi_valid, tag: hi_tag, data: '{hi: hi_data, lo: '0}};
  assign ret_lo = '{valid: lo_valid, tag: lo_tag, data: '{hi: '0, lo: lo_data}};
  assign ret    = ret_hi | ret_lo;  // idle halves are all zero, so OR merges them.

endmodule

`default_nettype wire

//--- src/lane_shuffle.sv
`timescale 1ns/1ps
`default_nettype none

module lane_shuffle #(
  parameter int lane_w = simd_pkg::half_w,
  parameter int tag_bits = simd_pkg::tag_w
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [lane_w-1:0]   opnd_a,
  input  logic [lane_w-1:0]   opnd_b,
  input  logic [lane_w-1:0]   other_a,
  input  logic [lane_w-1:0]   other_b,
  input  simd_pkg::src_t      src,
  input  logic                v,
  input  logic [tag_bits-1:0] tag,
  output logic [lane_w-1:0]   x_a,
  output logic [lane_w-1:0]   x_b,
  output logic                r_valid,
  output logic [tag_bits-1:0] r_tag,
  output logic [lane_w-1:0]   r_data
);
  import simd_pkg::*;

  logic [lane_w-1:0] pick;
  logic [lane_w-1:0] res_q;

  // stage 1 operand capture, also seen by the opposite half.
  always_ff @(posedge clk) begin
    x_a <= opnd_a;
    x_b <= opnd_b;
  end

  always_comb begin
    case (src)
      SRC_OWN_A:   pick = x_a;
      SRC_OWN_B:   pick = x_b;
      SRC_OTHER_A: pick = other_a;  // the other half's stage 1 A.
      SRC_OTHER_B: pick = other_b;
      default:     pick = x_a;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_q <= '0;
    end else begin
      res_q <= pick;
    end
  end

  // a disabled half contributes nothing to the shared return OR.
  assign r_valid = v;
  assign r_data  = v ? res_q : '0;
  assign r_tag   = v ? tag : '0;

endmodule

`default_nettype wire

//--- src/operand_mux.sv
`timescale 1ns/1ps
`default_nettype none

module operand_mux #(
  parameter int lane_w = simd_pkg::half_w
) (
  input  logic [lane_w-1:0] reg_val,
  input  logic [lane_w-1:0] fwd0,
  input  logic [lane_w-1:0] fwd1,
  input  logic [lane_w-1:0] fwd2,
  input  logic [lane_w-1:0] alt_val,
  input  logic [1:0]        fwd_sel,
  input  logic              use_alt,
  output logic [lane_w-1:0] opnd
);
  import simd_pkg::*;

  // slot 0 holds the register file value, the rest follow bus order.
  logic [lane_w-1:0] pool [0:n_fwd];

  always_comb begin
    pool[0] = reg_val;
    pool[1] = fwd0;
    pool[2] = fwd1;
    pool[3] = fwd2;
  end

  assign opnd = use_alt ? alt_val : pool[fwd_sel];  // alternate data beats any bypass.

endmodule

`default_nettype wire

//--- src/shuffle_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module shuffle_ctrl #(
  parameter int tag_bits = simd_pkg::tag_w
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                en,
  input  simd_pkg::issue_t    iss,
  output simd_pkg::src_t      src_hi,
  output simd_pkg::src_t      src_lo,
  output logic                v_hi,
  output logic                v_lo,
  output logic [tag_bits-1:0] tag
);
  import simd_pkg::*;

  logic                legal;
  src_t                dec_hi;
  src_t                dec_lo;
  logic [1:0]          v1_q;  // per-half valid, bit 1 is the high half.
  logic [1:0]          v2_q;
  logic [tag_bits-1:0] tag1_q;
  logic [tag_bits-1:0] tag2_q;

  always_comb begin
    legal  = 1'b1;
    dec_hi = SRC_OWN_A;
    dec_lo = SRC_OWN_A;
    case (iss.op)
      OP_PASS: begin
        dec_hi = SRC_OWN_A;
        dec_lo = SRC_OWN_A;
      end
      OP_SWAP: begin
        dec_hi = SRC_OTHER_A;
        dec_lo = SRC_OTHER_A;
      end
      OP_BCAST_LO: begin
        dec_hi = SRC_OTHER_A;
        dec_lo = SRC_OWN_A;
      end
      OP_BCAST_HI: begin
        dec_hi = SRC_OWN_A;
        dec_lo = SRC_OTHER_A;
      end
      OP_BLEND: begin
        dec_hi = SRC_OTHER_B;  // high lane takes B from the low half.
        dec_lo = SRC_OWN_A;
      end
      default: legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      src_hi <= SRC_OWN_A;
      src_lo <= SRC_OWN_A;
      v1_q   <= 2'b00;
      v2_q   <= 2'b00;
    end else begin
      src_hi <= dec_hi;
      src_lo <= dec_lo;
      v1_q   <= (en && legal) ? iss.lane_en : 2'b00;
      v2_q   <= v1_q;
    end
  end

  // tag follows the valid bits down both stages.
  always_ff @(posedge clk) begin
    tag1_q <= iss.tag;
    tag2_q <= tag1_q;
  end

  assign v_hi = v2_q[1];
  assign v_lo = v2_q[0];
  assign tag  = tag2_q;

endmodule

`default_nettype wire

//--- src/simd_pkg.sv
`default_nettype none

package simd_pkg;

  localparam int half_w = 68;
  localparam int tag_w = 14;
  localparam int n_fwd = 3;

  // one 136-bit SIMD operand split at the lane boundary.
  typedef struct packed {
    logic [half_w-1:0] hi;
    logic [half_w-1:0] lo;
  } simd_word_t;

  typedef enum logic [2:0] {
    OP_PASS     = 3'd0,
    OP_SWAP     = 3'd1,
    OP_BCAST_LO = 3'd2,
    OP_BCAST_HI = 3'd3,
    OP_BLEND    = 3'd4
  } op_t;

  typedef enum logic [1:0] {
    SRC_OWN_A   = 2'd0,
    SRC_OWN_B   = 2'd1,
    SRC_OTHER_A = 2'd2,
    SRC_OTHER_B = 2'd3
  } src_t;

  typedef struct packed {
    op_t              op;
    logic [tag_w-1:0] tag;
    logic [1:0]       lane_en;  // bit 1 is the high half.
  } issue_t;

  typedef struct packed {
    logic [1:0] fwd_a;  // 0 picks the register value.
    logic [1:0] fwd_b;
    logic [1:0] alt;
  } opsel_t;

  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] tag;
    simd_word_t       data;
  } ret_t;

endpackage

`default_nettype wire

//--- tb/tb_fp_shuffle_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_shuffle_unit;
  import simd_pkg::*;

  localparam int n_reset   = 3;
  localparam int n_idle    = 4;
  localparam int n_ops     = 5 * 4;
  localparam int n_sel     = 4 * 4 * 4 * 2;
  localparam int n_mask    = 5 * 3;
  localparam int n_illegal = 3;
  localparam int n_rand    = 200;
  localparam int n_drain   = 4;
  localparam int run_cycles = n_reset + n_idle + n_ops + n_sel + n_mask + n_illegal
                              + n_rand + n_drain;
  localparam int timeout_cycles = run_cycles + 20;

  logic       clk;
  logic       rst;
  logic       en;
  issue_t     iss;
  opsel_t     sel;
  simd_word_t reg_a;
  simd_word_t reg_b;
  simd_word_t fwd0;
  simd_word_t fwd1;
  simd_word_t fwd2;
  simd_word_t alt0;
  simd_word_t alt1;
  ret_t       ret;

  integer seed = 64;
  int     cycles = 0;
  logic   checking = 1'b0;
  ret_t   pipe [0:1];  // expected returns, index 1 is due at the next check.

  fp_shuffle_unit #(.lane_w(half_w), .tag_bits(tag_w)) u_fp_shuffle_unit (
    .clk(clk), .rst(rst), .en(en), .iss(iss), .sel(sel),
    .reg_a(reg_a), .reg_b(reg_b), .fwd0(fwd0), .fwd1(fwd1), .fwd2(fwd2),
    .alt0(alt0), .alt1(alt1), .ret(ret)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [half_w-1:0] rand_half();
    logic [95:0] bits;
    bits = {$random(seed), $random(seed), $random(seed)};
    return bits[half_w-1:0];
  endfunction

  function automatic simd_word_t rand_word();
    simd_word_t w;
    w.hi = rand_half();
    w.lo = rand_half();
    return w;
  endfunction

  function automatic simd_word_t pick_operand(input simd_word_t regw, input simd_word_t f0,
                                              input simd_word_t f1, input simd_word_t f2,
                                              input simd_word_t altw, input logic [1:0] fsel,
                                              input logic use_alt);
    simd_word_t w;
    if (use_alt) begin
      w = altw;
    end else begin
      case (fsel)
        2'd0:    w = regw;
        2'd1:    w = f0;
        2'd2:    w = f1;
        default: w = f2;
      endcase
    end
    return w;
  endfunction

  function automatic ret_t expected_return(input logic issue, input issue_t i, input opsel_t s,
                                           input simd_word_t ra, input simd_word_t rb,
                                           input simd_word_t f0, input simd_word_t f1,
                                           input simd_word_t f2, input simd_word_t a0,
                                           input simd_word_t a1);
    ret_t       r;
    simd_word_t a;
    simd_word_t b;
    logic       ok;
    r  = '0;
    ok = 1'b1;
    a  = pick_operand(ra, f0, f1, f2, a0, s.fwd_a, s.alt[0]);
    b  = pick_operand(rb, f0, f1, f2, a1, s.fwd_b, s.alt[1]);
    case (i.op)
      OP_PASS: begin
        r.data.hi = a.hi;
        r.data.lo = a.lo;
      end
      OP_SWAP: begin
        r.data.hi = a.lo;
        r.data.lo = a.hi;
      end
      OP_BCAST_LO: begin
        r.data.hi = a.lo;
        r.data.lo = a.lo;
      end
      OP_BCAST_HI: begin
        r.data.hi = a.hi;
        r.data.lo = a.hi;
      end
      OP_BLEND: begin
        r.data.hi = b.lo;  // low half of B lands in the high lane.
        r.data.lo = a.lo;
      end
      default: ok = 1'b0;
    endcase
    if (!issue || !ok || i.lane_en == 2'b00) begin
      r = '0;
    end else begin
      r.valid = 1'b1;
      r.tag   = i.tag;
      if (!i.lane_en[1]) r.data.hi = '0;
      if (!i.lane_en[0]) r.data.lo = '0;
    end
    return r;
  endfunction

  task automatic stop_with_failure();
    $display("TEST FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_return(input ret_t exp);
    assert (ret.valid === exp.valid) else begin
      $display("Fail ret.valid expected %h got %h", exp.valid, ret.valid);
      stop_with_failure();
    end
    assert (ret.tag === exp.tag) else begin
      $display("Fail ret.tag expected %h got %h", exp.tag, ret.tag);
      stop_with_failure();
    end
    assert (ret.data === exp.data) else begin
      $display("Fail ret.data expected %h got %h", exp.data, ret.data);
      stop_with_failure();
    end
  endtask

  task automatic issue_item(input logic [2:0] op, input logic [1:0] lanes,
                            input logic [1:0] fa, input logic [1:0] fb, input logic [1:0] alt);
    issue_t      it;
    opsel_t      s;
    logic [31:0] t;
    t          = $random(seed);
    it.op      = op_t'(op);
    it.tag     = t[tag_w-1:0];
    it.lane_en = lanes;
    s.fwd_a    = fa;
    s.fwd_b    = fb;
    s.alt      = alt;
    @(posedge clk);
    en    <= 1'b1;
    iss   <= it;
    sel   <= s;
    reg_a <= rand_word();
    reg_b <= rand_word();
    fwd0  <= rand_word();
    fwd1  <= rand_word();
    fwd2  <= rand_word();
    alt0  <= rand_word();
    alt1  <= rand_word();
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    en <= 1'b0;  // issue fields stay put, so en alone must gate them.
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > timeout_cycles) begin
      $display("timeout after %0d cycles, the stimulus never reached its end", cycles);
      stop_with_failure();
    end
  end

  // outputs settle between edges, so the comparison runs on the falling edge.
  always @(negedge clk) begin
    if (checking) begin
      check_return(pipe[1]);
    end
    pipe[1] = pipe[0];
    pipe[0] = expected_return(en, iss, sel, reg_a, reg_b, fwd0, fwd1, fwd2, alt0, alt1);
  end

  initial begin
    logic [31:0] r;
    rst   = 1'b1;
    en    = 1'b0;
    iss   = '0;
    sel   = '0;
    reg_a = '0;
    reg_b = '0;
    fwd0  = '0;
    fwd1  = '0;
    fwd2  = '0;
    alt0  = '0;
    alt1  = '0;
    repeat (n_reset) @(posedge clk);
    rst      <= 1'b0;
    checking <= 1'b1;
    repeat (n_idle) idle_cycle();

    for (int k = 0; k < 5; k++) begin
      issue_item(k[2:0], 2'b11, 2'd0, 2'd0, 2'b00);
      repeat (3) idle_cycle();
    end

    // blend shows A.lo and B.lo, swap shows both halves of A.
    for (int fa = 0; fa < 4; fa++) begin
      for (int fb = 0; fb < 4; fb++) begin
        for (int al = 0; al < 4; al++) begin
          issue_item(OP_BLEND, 2'b11, fa[1:0], fb[1:0], al[1:0]);
          issue_item(OP_SWAP, 2'b11, fa[1:0], fb[1:0], al[1:0]);
        end
      end
    end

    for (int k = 0; k < 5; k++) begin
      for (int m = 0; m < 3; m++) begin
        issue_item(k[2:0], m[1:0], 2'd0, 2'd0, 2'b00);
      end
    end

    for (int k = 5; k < 8; k++) begin
      issue_item(k[2:0], 2'b11, 2'd0, 2'd0, 2'b00);
    end

    repeat (n_rand) begin
      r = $random(seed);
      issue_item(r[2:0], r[4:3], r[6:5], r[8:7], r[10:9]);
    end

    repeat (n_drain) idle_cycle();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
